/* fpAddSub.f */
+incdir+.
fpFormatPkg.sv
fpPipePkg.sv
fpAddSubAlign.sv
fpAddSubNormalize.sv
fpAddSubExecute.sv
fpAddSubRound.sv
fpAddSub.sv
fpAddSub_properties.sv
fpAddSub_tb.sv

/* fpAddSub.sv */
`timescale 1ns/1ps

module fpAddSub (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	input  fpFormatPkg::fp16T opA,
	input  fpFormatPkg::fp16T opB,
	input  fpPipePkg::fpOpE op,
	output logic outValid,
	output fpFormatPkg::fp16T result
);
	import fpPipePkg::*;

	// Inter-stage registers
	alignStageT alignStage;
	execStageT execStage;

	// Classify, swap, align
	fpAddSubAlign uAlign (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.opA(opA),
		.opB(opB),
		.op(op),
		.stage(alignStage)
	);

	// Add or subtract, then normalize
	fpAddSubExecute uExecute (
		.clk(clk),
		.arstN(arstN),
		.inStage(alignStage),
		.outStage(execStage)
	);

	// Round, range check, pack
	fpAddSubRound uRound (
		.clk(clk),
		.arstN(arstN),
		.inStage(execStage),
		.outValid(outValid),
		.result(result)
	);

endmodule

/* fpAddSubAlign.sv */
`timescale 1ns/1ps
`include "fp_defs.svh"

module fpAddSubAlign (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	input  fpFormatPkg::fp16T opA,
	input  fpFormatPkg::fp16T opB,
	input  fpPipePkg::fpOpE op,
	output fpPipePkg::alignStageT stage
);
	import fpFormatPkg::*;
	import fpPipePkg::*;

	// Wide enough that the largest exponent gap still keeps every lost bit
	localparam int extWidth = `SUMWIDTH + (1 << `EXPONENT) - 1;

	fp16T bEff;
	fp16T opLarge;
	fp16T opSmall;
	fpClassE classA;
	fpClassE classB;
	logic [`EXPONENT-1:0] expDiff;
	logic [`SUMWIDTH-1:0] mantSmallRaw;
	logic [extWidth-1:0] shiftedExt;
	alignStageT nextStage;

	// Subtract is add with B negated
	always_comb begin
		bEff = opB;
		bEff.sign = opB.sign ^ (op == opSub);
	end

	assign classA = classify(opA);
	assign classB = classify(bEff);

	// Larger magnitude first, a tie keeps A in front
	always_comb begin
		if ({opA.exponent, opA.fraction} >= {bEff.exponent, bEff.fraction}) begin
			opLarge = opA;
			opSmall = bEff;
		end else begin
			opLarge = bEff;
			opSmall = opA;
		end
	end

	assign expDiff = opLarge.exponent - opSmall.exponent;

	// Hidden one at bit 13, GRS cleared
	assign mantSmallRaw = {2'b01, opSmall.fraction, 3'b000};

	// Bits shifted out end up below the working width
	assign shiftedExt = {mantSmallRaw, {(extWidth - `SUMWIDTH){1'b0}}} >> expDiff;

	always_comb begin
		nextStage = '0;
		nextStage.valid = inValid;
		nextStage.sign = opLarge.sign;
		nextStage.effSub = opA.sign ^ bEff.sign;
		nextStage.exponent = opLarge.exponent;
		nextStage.mantLarge = {2'b01, opLarge.fraction, 3'b000};
		// Sticky is the OR of everything that fell off
		nextStage.mantSmall = shiftedExt[extWidth-1 -: `SUMWIDTH]
			| `SUMWIDTH'(|shiftedExt[extWidth-`SUMWIDTH-1:0]);
		// Special cases, NaN has top priority
		if (classA == clsNan || classB == clsNan) begin
			nextStage.special = 1'b1;
			nextStage.specialResult = canonNan;
		end else if (classA == clsInf && classB == clsInf) begin
			// Opposite infinities are invalid
			nextStage.special = 1'b1;
			nextStage.specialResult = (opA.sign == bEff.sign) ? opA : canonNan;
		end else if (classA == clsInf) begin
			nextStage.special = 1'b1;
			nextStage.specialResult = opA;
		end else if (classB == clsInf) begin
			nextStage.special = 1'b1;
			nextStage.specialResult = bEff;
		end else if (classA == clsZero && classB == clsZero) begin
			// -0 only when both zeros are negative
			nextStage.special = 1'b1;
			nextStage.specialResult.sign = opA.sign & bEff.sign;
		end else if (classA == clsZero) begin
			nextStage.special = 1'b1;
			nextStage.specialResult = bEff;
		end else if (classB == clsZero) begin
			nextStage.special = 1'b1;
			nextStage.specialResult = opA;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stage <= '0;
		end else begin
			stage <= nextStage;
		end
	end

endmodule

/* fpAddSubExecute.sv */
`timescale 1ns/1ps
`include "fp_defs.svh"

module fpAddSubExecute (
	input  logic clk,
	input  logic arstN,
	input  fpPipePkg::alignStageT inStage,
	output fpPipePkg::execStageT outStage
);
	import fpPipePkg::*;

	logic [`SUMWIDTH-1:0] sum;
	logic [`SUMWIDTH-1:0] normMant;
	logic [`SHIFTWIDTH-1:0] normShift;
	logic normZero;
	execStageT nextStage;

	// Larger magnitude comes first, so no negative difference
	assign sum = inStage.effSub ? inStage.mantLarge - inStage.mantSmall
		: inStage.mantLarge + inStage.mantSmall;

	fpAddSubNormalize uNormalize (
		.sum(sum),
		.mantissa(normMant),
		.shift(normShift),
		.zero(normZero)
	);

	always_comb begin
		nextStage.valid = inStage.valid;
		// Exact cancellation gives +0
		nextStage.sign = inStage.sign & ~normZero;
		// One up for the carry position, down by the shift
		nextStage.exponent = $signed({2'b00, inStage.exponent}) + 7'sd1
			- $signed({3'b000, normShift});
		nextStage.mantissa = normMant;
		nextStage.zero = normZero;
		// Specials ride along untouched
		nextStage.special = inStage.special;
		nextStage.specialResult = inStage.specialResult;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outStage <= '0;
		end else begin
			outStage <= nextStage;
		end
	end

endmodule

/* fpAddSubNormalize.sv */
`timescale 1ns/1ps
`include "fp_defs.svh"

module fpAddSubNormalize (
	input  logic [`SUMWIDTH-1:0] sum,
	output logic [`SUMWIDTH-1:0] mantissa,
	output logic [`SHIFTWIDTH-1:0] shift,
	output logic zero
);
	// Barrel shifter levels
	logic [`SUMWIDTH-1:0] lvl8;
	logic [`SUMWIDTH-1:0] lvl4;
	logic [`SUMWIDTH-1:0] lvl2;

	// Leading one search, carry bit has priority
	assign shift =
		sum[14] ? 4'd0 :
		sum[13] ? 4'd1 :
		sum[12] ? 4'd2 :
		sum[11] ? 4'd3 :
		sum[10] ? 4'd4 :
		sum[9]  ? 4'd5 :
		sum[8]  ? 4'd6 :
		sum[7]  ? 4'd7 :
		sum[6]  ? 4'd8 :
		sum[5]  ? 4'd9 :
		sum[4]  ? 4'd10 :
		sum[3]  ? 4'd11 :
		sum[2]  ? 4'd12 :
		sum[1]  ? 4'd13 : 4'd14;

	// Nothing to find when the difference cancels
	assign zero = ~|sum;

	// Left shift in binary steps
	assign lvl8 = shift[3] ? {sum[`SUMWIDTH-9:0], 8'b0} : sum;
	assign lvl4 = shift[2] ? {lvl8[`SUMWIDTH-5:0], 4'b0} : lvl8;
	assign lvl2 = shift[1] ? {lvl4[`SUMWIDTH-3:0], 2'b0} : lvl4;

	// Leading one now in the carry position
	assign mantissa = shift[0] ? {lvl2[`SUMWIDTH-2:0], 1'b0} : lvl2;

endmodule

/* fpAddSubRound.sv */
`timescale 1ns/1ps
`include "fp_defs.svh"

module fpAddSubRound (
	input  logic clk,
	input  logic arstN,
	input  fpPipePkg::execStageT inStage,
	output logic outValid,
	output fpFormatPkg::fp16T result
);
	import fpFormatPkg::*;

	// All-ones biased exponent is reserved for inf and NaN
	localparam int expMax = 2 * `BIAS + 1;

	logic [`MANTISSA-1:0] frac;
	logic guardBit;
	logic roundBit;
	logic stickyBit;
	logic roundUp;
	logic [`MANTISSA+1:0] rounded;
	logic [`MANTISSA-1:0] fracRounded;
	logic signed [6:0] expRounded;
	fp16T nextResult;

	// Fraction sits just below the leading one in the carry position
	assign frac = inStage.mantissa[`SUMWIDTH-2 -: `MANTISSA];
	assign guardBit = inStage.mantissa[3];
	assign roundBit = inStage.mantissa[2];
	assign stickyBit = |inStage.mantissa[1:0];

	// Ties round up only from an odd fraction
	assign roundUp = guardBit & (roundBit | stickyBit | frac[0]);

	assign rounded = {2'b01, frac} + {{(`MANTISSA + 1){1'b0}}, roundUp};

	// A carry out leaves the fraction all zero and bumps the exponent
	assign fracRounded = rounded[`MANTISSA-1:0];
	assign expRounded = inStage.exponent + $signed({6'b0, rounded[`MANTISSA+1]});

	always_comb begin
		nextResult.sign = inStage.sign;
		nextResult.exponent = expRounded[`EXPONENT-1:0];
		nextResult.fraction = fracRounded;
		if (inStage.special) begin
			nextResult = inStage.specialResult;
		end else if (inStage.zero || expRounded <= 0) begin
			// Flush to signed zero below the normal range
			nextResult.exponent = '0;
			nextResult.fraction = '0;
		end else if (expRounded >= expMax) begin
			// Overflow to signed infinity
			nextResult.exponent = '1;
			nextResult.fraction = '0;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
			result <= '0;
		end else begin
			outValid <= inStage.valid;
			result <= nextResult;
		end
	end

endmodule

/* fpAddSub_properties.sv */
`timescale 1ns/1ps
`include "fp_defs.svh"

module fpAddSub_properties (
	input logic clk,
	input logic arstN,
	input logic inValid,
	input fpFormatPkg::fp16T opA,
	input fpFormatPkg::fp16T opB,
	input logic outValid,
	input fpFormatPkg::fp16T result
);
	// All-ones exponent with a nonzero fraction
	logic nanIn;

	assign nanIn = (opA.exponent == '1 && opA.fraction != '0)
		|| (opB.exponent == '1 && opB.fraction != '0);

	// One output strobe per input strobe, fixed latency
	latencyCheck: assert property (@(posedge clk) disable iff (!arstN)
		outValid == $past(inValid, `LATENCY))
		else $error("outValid does not follow inValid by the pipeline latency");

	resultKnown: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> !$isunknown(result))
		else $error("result has X or Z bits while outValid is high");

	nanPropagates: assert property (@(posedge clk) disable iff (!arstN)
		inValid && nanIn |-> ##`LATENCY (result.exponent == '1 && result.fraction != '0))
		else $error("NaN operand did not give a NaN result");

endmodule

bind fpAddSub fpAddSub_properties uProps (.*);

/* fpAddSub_tb.sv */
`timescale 1ns/1ps
`include "fp_defs.svh"

module fpAddSub_tb;
	import fpFormatPkg::*;
	import fpPipePkg::*;

	// One issued operation with its predicted result
	typedef struct packed {
		logic [15:0] a;
		logic [15:0] b;
		logic sub;
		logic [15:0] expected;
		int issued;
	} txnT;

	localparam int numRandom = 1200;
	localparam int numDirected = 200;
	localparam int totalOps = numRandom + 3 * numDirected;
	// At most 3 cycles per op with gaps plus reset and drain
	localparam int maxCycles = 3 * totalOps + 600;

	logic clk = 1'b0;
	logic arstN;
	logic inValid;
	fp16T opA;
	fp16T opB;
	fpOpE op;
	logic outValid;
	fp16T result;

	logic [15:0] lfsrState = 16'd40;
	txnT expectQ[$];
	txnT want;
	int cycles = 0;

	fpAddSub u_dut (.*);

	always #50 clk = ~clk;

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsrNext(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit
	function automatic logic [15:0] randBits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
		return v;
	endfunction

	// Exact value in units of 2^-24 with subnormals as zero
	function automatic longint toFixed(logic [15:0] x);
		longint mag;
		if (x[14:10] == 5'd0)
			return 64'sd0;
		mag = (64'd1024 + x[9:0]) << (x[14:10] - 5'd1);
		return x[15] ? -mag : mag;
	endfunction

	function automatic logic [15:0] modelAddSub(logic [15:0] a, logic [15:0] b, logic sub);
		logic [15:0] bEff;
		logic aNan;
		logic bNan;
		longint sum;
		longint mag;
		longint q;
		longint rem;
		longint half;
		int msb;
		int sh;
		bEff = {b[15] ^ sub, b[14:0]};
		aNan = a[14:10] == 5'h1F && a[9:0] != '0;
		bNan = b[14:10] == 5'h1F && b[9:0] != '0;
		if (aNan || bNan)
			return 16'h7E00;
		if (a[14:0] == 15'h7C00 && b[14:0] == 15'h7C00)
			return (a[15] == bEff[15]) ? a : 16'h7E00;
		if (a[14:0] == 15'h7C00)
			return a;
		if (b[14:0] == 15'h7C00)
			return bEff;
		sum = toFixed(a) + toFixed(bEff);
		// -0 only from two negative zeros
		if (sum == 0)
			return {a[15] & bEff[15] & (a[14:10] == 5'd0) & (b[14:10] == 5'd0), 15'h0};
		mag = (sum < 0) ? -sum : sum;
		msb = 0;
		for (int i = 0; i < 63; i++) begin
			if (mag[i])
				msb = i;
		end
		sh = msb - 10;
		// Keep 11 significant bits with ties to even
		if (sh > 0) begin
			q = mag >> sh;
			rem = mag - (q << sh);
			half = 64'sd1 <<< (sh - 1);
			if (rem > half || (rem == half && q[0]))
				q++;
			if (q == 2048) begin
				q = 1024;
				sh++;
			end
		end else begin
			q = mag << (-sh);
		end
		// q * 2^(sh-24) has biased exponent sh+1
		if (sh + 1 <= 0)
			return {sum < 0, 15'h0};
		if (sh + 1 >= 31)
			return {sum < 0, 15'h7C00};
		return {sum < 0, 5'(sh + 1), q[9:0]};
	endfunction

	// Zero, subnormal, infinity, NaN, or leave it normal
	function automatic logic [15:0] specialOperand(logic [15:0] x);
		logic [15:0] y;
		y = x;
		case (randBits(3))
			0: y[14:0] = '0;
			1: y[14:10] = '0;
			2: y[14:0] = 15'h7C00;
			3: y = {x[15], 5'h1F, x[9:1], 1'b1};
			default: ;
		endcase
		return y;
	endfunction

	// Mode 0 random normal, 1 cancellation, 2 specials, 3 range limits
	function automatic txnT makeTxn(int mode);
		txnT t;
		int eb;
		int mag;
		int off;
		t = '0;
		t.sub = randBits(1) != 0;
		t.a = randBits(16);
		t.a[14:10] = 5'(1 + randBits(5) % 30);
		t.b = randBits(16);
		t.b[14:10] = 5'(1 + randBits(5) % 30);
		case (mode)
			0: begin
				// Nearby exponents so the operands interact
				eb = int'(t.a[14:10]) + int'(randBits(4)) - 8;
				t.b[14:10] = 5'((eb < 1) ? 1 : (eb > 30) ? 30 : eb);
			end
			1: begin
				// Effective subtract a few ulps apart where zero offset gives x - x
				off = int'(randBits(int'(randBits(4) % 11)));
				mag = int'(t.a[14:0]) + ((randBits(1) != 0) ? off : -off);
				if (mag < 'h400 || mag >= 'h7C00)
					mag = int'(t.a[14:0]);
				t.b = {~t.a[15] ^ t.sub, 15'(mag)};
			end
			2: begin
				t.a = specialOperand(t.a);
				t.b = specialOperand(t.b);
			end
			3: begin
				if (randBits(1) != 0) begin
					// Same sign near the top
					t.a[14:10] = 5'(28 + randBits(2) % 3);
					t.b[14:10] = 5'(28 + randBits(2) % 3);
					t.b[15] = t.a[15] ^ t.sub;
				end else begin
					// Differences near the bottom of the normal range
					t.a[14:10] = 5'(1 + randBits(1));
					t.b[14:10] = 5'(1 + randBits(1));
					t.b[15] = ~t.a[15] ^ t.sub;
				end
			end
			default: ;
		endcase
		t.expected = modelAddSub(t.a, t.b, t.sub);
		return t;
	endfunction

	task automatic issueTxn(txnT t);
		@(posedge clk);
		inValid <= 1'b1;
		opA <= t.a;
		opB <= t.b;
		if (t.sub)
			op <= opSub;
		else
			op <= opAdd;
		t.issued = cycles;
		expectQ.push_back(t);
		// Idle gap of 1 or 2 cycles one time in four
		if (randBits(2) == 0) begin
			repeat (1 + randBits(1)) begin
				@(posedge clk);
				inValid <= 1'b0;
			end
		end
	endtask

	task automatic failRun(string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= maxCycles)
			failRun($sformatf("Timeout after %0d cycles, results stopped coming", cycles));
	end

	// Outputs are settled mid-cycle
	always @(negedge clk) begin
		if (outValid) begin
			assert (expectQ.size() > 0)
				else failRun($sformatf("Unexpected result %h at %0d ns", result, $time));
			if (expectQ.size() > 0) begin
				want = expectQ.pop_front();
				// Driven one edge before the DUT samples it
				assert (cycles - want.issued == `LATENCY + 1)
					else failRun($sformatf("Result at %0d ns came %0d cycles after issue",
						$time, cycles - want.issued - 1));
				assert (result === want.expected)
					else failRun($sformatf("[FAIL] %0d ns: %h %s %h gave %h, expected %h",
						$time, want.a, want.sub ? "-" : "+", want.b, result, want.expected));
			end
		end
	end

	initial begin
		arstN = 1'b0;
		inValid = 1'b0;
		opA = '0;
		opB = '0;
		op = opAdd;
		repeat (5) @(posedge clk);
		arstN <= 1'b1;
		for (int i = 0; i < numRandom; i++)
			issueTxn(makeTxn(0));
		for (int mode = 1; mode < 4; mode++) begin
			for (int i = 0; i < numDirected; i++)
				issueTxn(makeTxn(mode));
		end
		@(posedge clk);
		inValid <= 1'b0;
		// Drain plus margin for stray strobes
		repeat (`LATENCY + 4) @(posedge clk);
		if (expectQ.size() != 0) begin
			failRun($sformatf("%0d operations never produced a result", expectQ.size()));
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

/* fpFormatPkg.sv */
`include "fp_defs.svh"

package fpFormatPkg;

	// Sign, biased exponent, fraction without hidden bit
	typedef struct packed {
		logic sign;
		logic [`EXPONENT-1:0] exponent;
		logic [`MANTISSA-1:0] fraction;
	} fp16T;

	// Operand class, subnormals count as zero
	typedef enum logic [1:0] {clsZero, clsNormal, clsInf, clsNan} fpClassE;

	// Canonical quiet NaN
	localparam logic [`DWIDTH-1:0] canonNanBits = 16'h7E00;
	localparam fp16T canonNan = fp16T'(canonNanBits);

	function automatic fpClassE classify(fp16T x);
		// Zero exponent means zero or a flushed subnormal
		if (x.exponent == '0) return clsZero;
		if (x.exponent == '1) return (x.fraction == '0) ? clsInf : clsNan;
		return clsNormal;
	endfunction

endpackage

/* fpPipePkg.sv */
`include "fp_defs.svh"

package fpPipePkg;

	typedef enum logic {opAdd, opSub} fpOpE;

	// Align stage to execute stage
	typedef struct packed {
		logic valid;
		// Sign of the larger operand
		logic sign;
		// Operand signs differ after op is applied
		logic effSub;
		logic [`EXPONENT-1:0] exponent;
		logic [`SUMWIDTH-1:0] mantLarge;
		// Shifted right, lost bits folded into sticky
		logic [`SUMWIDTH-1:0] mantSmall;
		logic special;
		fpFormatPkg::fp16T specialResult;
	} alignStageT;

	// Execute stage to round stage
	typedef struct packed {
		logic valid;
		logic sign;
		// Biased, leading one sits in the carry position
		logic signed [6:0] exponent;
		logic [`SUMWIDTH-1:0] mantissa;
		// Exact cancellation
		logic zero;
		logic special;
		fpFormatPkg::fp16T specialResult;
	} execStageT;

endpackage

/* fp_defs.svh */
`ifndef FP_DEFS_SVH
`define FP_DEFS_SVH

// FP16 field widths
`define EXPONENT 5
`define MANTISSA 10
`define DWIDTH (1 + `EXPONENT + `MANTISSA)

// Exponent bias
`define BIAS 15

// Working mantissa, carry + hidden + fraction + guard/round/sticky
`define SUMWIDTH 15

// Normalize shift amount, covers 0 to 14
`define SHIFTWIDTH 4

// Cycles from input strobe to output strobe
`define LATENCY 3

`endif
